/* common/fastica_pkg.sv */
package fastica_pkg;

    // fixed-point format, Q2.14
    localparam int FRAC_BITS = 14;

    localparam int N_SAMPLES = 16;
    localparam int LOG2_N = 4;
    localparam int MAX_ITER = 8;
    localparam int ORTH_STEPS = 3;

    typedef logic signed [15:0] fix_t;
    typedef logic signed [39:0] acc_t;
    typedef logic [LOG2_N-1:0] addr_t;
    typedef logic [3:0] iter_t;

    localparam fix_t FIX_ONE = 16'sh4000;
    localparam acc_t FIX_MAX = 40'sd32767;
    localparam acc_t FIX_MIN = -40'sd32768;
    // about 0.001 in Q2.14
    localparam fix_t CONV_EPS = 16'sd16;

    typedef struct packed {
        fix_t ch1;
        fix_t ch0;
    } sample_t;

    typedef struct packed {
        fix_t c1;
        fix_t c0;
    } weight_row_t;

    typedef struct packed {
        weight_row_t row1;
        weight_row_t row0;
    } weight_mat_t;

    typedef enum logic [2:0] {
        idle,
        orthogonalize,
        snapshot,
        update,
        converge_test,
        project
    } phase_t;

    // clamp a wide value back into Q2.14 range
    function automatic fix_t sat_fix(input acc_t v);
        if (v > FIX_MAX) begin
            return 16'sh7fff;
        end
        if (v < FIX_MIN) begin
            return 16'sh8000;
        end
        return fix_t'(v);
    endfunction

    // product kept at Q14 scale, not saturated
    function automatic acc_t qmul(input fix_t a, input fix_t b);
        return (acc_t'(a) * acc_t'(b)) >>> FRAC_BITS;
    endfunction

    function automatic acc_t dot2(input fix_t a0, input fix_t a1, input fix_t b0, input fix_t b1);
        return qmul(a0, b0) + qmul(a1, b1);
    endfunction

endpackage

/* hw/sample_ram.sv */
module sample_ram (
    input  logic                 clk_fastica,
    input  logic                 wr,
    input  logic                 busy,
    input  fastica_pkg::addr_t   wr_addr,
    input  fastica_pkg::sample_t wr_data,
    input  fastica_pkg::addr_t   addr_a,
    input  fastica_pkg::addr_t   addr_b,
    output fastica_pkg::sample_t data_a,
    output fastica_pkg::sample_t data_b
);

    fastica_pkg::sample_t mem [fastica_pkg::N_SAMPLES];

    always_ff @(posedge clk_fastica) begin
        // host loads are dropped while a run is in progress
        if (wr && !busy) begin
            mem[wr_addr] <= wr_data;
        end
        data_a <= mem[addr_a];
        data_b <= mem[addr_b];
    end

endmodule

/* hw/weight_bank.sv */
module weight_bank (
    input  logic                     clk_fastica,
    input  logic                     go_fastica,
    input  logic                     w_init,
    input  logic                     go_snap,
    input  logic                     orth_valid,
    input  fastica_pkg::weight_mat_t w_orth,
    input  logic                     upd_valid,
    input  fastica_pkg::weight_mat_t w_upd,
    input  logic                     proj_en,
    input  fastica_pkg::sample_t     data_b,
    output fastica_pkg::weight_mat_t w,
    output fastica_pkg::weight_mat_t w_prev,
    output logic                     out_valid,
    output fastica_pkg::sample_t     out_sample
);

    always_ff @(posedge clk_fastica) begin
        if (w_init) begin
            w.row0 <= '{c1: '0, c0: fastica_pkg::FIX_ONE};
            w.row1 <= '{c1: fastica_pkg::FIX_ONE, c0: '0};
        end else if (orth_valid) begin
            w <= w_orth;
        end else if (upd_valid) begin
            w <= w_upd;
        end

        if (go_snap) begin
            w_prev <= w;
        end

        // separate with the orthonormal snapshot, the live W is unnormalised after update
        if (proj_en) begin
            out_sample.ch0 <= fastica_pkg::sat_fix(fastica_pkg::dot2(
                w_prev.row0.c0, w_prev.row0.c1, data_b.ch0, data_b.ch1));
            out_sample.ch1 <= fastica_pkg::sat_fix(fastica_pkg::dot2(
                w_prev.row1.c0, w_prev.row1.c1, data_b.ch0, data_b.ch1));
        end
    end

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= proj_en;
        end
    end

endmodule

/* hw/symm_orth/symm_orth.sv */
module symm_orth (
    input  logic                     clk_fastica,
    input  logic                     go_fastica,
    input  logic                     go_symm,
    input  fastica_pkg::weight_mat_t w_in,
    output logic                     symm_busy,
    output logic                     orth_valid,
    output fastica_pkg::weight_mat_t w_orth
);

    logic [$clog2(fastica_pkg::ORTH_STEPS + 1)-1:0] step_cnt;
    fastica_pkg::weight_mat_t w_loc;
    fastica_pkg::weight_mat_t w_scaled;
    fastica_pkg::weight_mat_t w_next;

    // divide by the power of two at or above the largest row abs sum
    function automatic fastica_pkg::weight_mat_t prescale(input fastica_pkg::weight_mat_t m);
        fastica_pkg::acc_t s0;
        fastica_pkg::acc_t s1;
        fastica_pkg::acc_t s;
        fastica_pkg::weight_mat_t r;
        int lsh;
        int rsh;
        s0 = (m.row0.c0 < 0 ? -m.row0.c0 : m.row0.c0) + (m.row0.c1 < 0 ? -m.row0.c1 : m.row0.c1);
        s1 = (m.row1.c0 < 0 ? -m.row1.c0 : m.row1.c0) + (m.row1.c1 < 0 ? -m.row1.c1 : m.row1.c1);
        s = (s0 > s1) ? s0 : s1;
        lsh = 0;
        rsh = 0;
        if (s > 2 * fastica_pkg::FIX_ONE) begin
            rsh = 2;
        end else if (s > fastica_pkg::FIX_ONE) begin
            rsh = 1;
        end
        // small matrices are scaled up, at most by 8
        for (int i = 1; i < 4; i++) begin
            if (s <= (fastica_pkg::FIX_ONE >>> i)) begin
                lsh = i;
            end
        end
        r.row0.c0 = (m.row0.c0 <<< lsh) >>> rsh;
        r.row0.c1 = (m.row0.c1 <<< lsh) >>> rsh;
        r.row1.c0 = (m.row1.c0 <<< lsh) >>> rsh;
        r.row1.c1 = (m.row1.c1 <<< lsh) >>> rsh;
        return r;
    endfunction

    // W <- 1.5W - 0.5 W Wt W, written as W + (W - P W)/2
    function automatic fastica_pkg::weight_mat_t orth_step(input fastica_pkg::weight_mat_t m);
        fastica_pkg::fix_t p00;
        fastica_pkg::fix_t p01;
        fastica_pkg::fix_t p11;
        fastica_pkg::acc_t q00;
        fastica_pkg::acc_t q01;
        fastica_pkg::acc_t q10;
        fastica_pkg::acc_t q11;
        fastica_pkg::weight_mat_t r;
        p00 = fastica_pkg::sat_fix(fastica_pkg::dot2(m.row0.c0, m.row0.c1, m.row0.c0, m.row0.c1));
        p01 = fastica_pkg::sat_fix(fastica_pkg::dot2(m.row0.c0, m.row0.c1, m.row1.c0, m.row1.c1));
        p11 = fastica_pkg::sat_fix(fastica_pkg::dot2(m.row1.c0, m.row1.c1, m.row1.c0, m.row1.c1));
        q00 = fastica_pkg::dot2(p00, p01, m.row0.c0, m.row1.c0);
        q01 = fastica_pkg::dot2(p00, p01, m.row0.c1, m.row1.c1);
        q10 = fastica_pkg::dot2(p01, p11, m.row0.c0, m.row1.c0);
        q11 = fastica_pkg::dot2(p01, p11, m.row0.c1, m.row1.c1);
        r.row0.c0 = fastica_pkg::sat_fix(m.row0.c0 + ((m.row0.c0 - q00) >>> 1));
        r.row0.c1 = fastica_pkg::sat_fix(m.row0.c1 + ((m.row0.c1 - q01) >>> 1));
        r.row1.c0 = fastica_pkg::sat_fix(m.row1.c0 + ((m.row1.c0 - q10) >>> 1));
        r.row1.c1 = fastica_pkg::sat_fix(m.row1.c1 + ((m.row1.c1 - q11) >>> 1));
        return r;
    endfunction

    assign w_scaled = prescale(w_in);
    assign w_next = orth_step(w_loc);
    assign w_orth = w_next;
    assign orth_valid = symm_busy && (step_cnt == fastica_pkg::ORTH_STEPS);

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            symm_busy <= 1'b0;
            step_cnt <= '0;
        end else if (go_symm) begin
            symm_busy <= 1'b1;
            step_cnt <= '0;
        end else if (symm_busy) begin
            step_cnt <= step_cnt + 1'b1;
            if (step_cnt == fastica_pkg::ORTH_STEPS) begin
                symm_busy <= 1'b0;
            end
        end
    end

    // step 0 takes w_in one cycle after go, once any identity load has landed
    always_ff @(posedge clk_fastica) begin
        if (symm_busy) begin
            w_loc <= (step_cnt == 0) ? w_scaled : w_next;
        end
    end

endmodule

/* hw/fast_update/fast_update.sv */
module fast_update (
    input  logic                     clk_fastica,
    input  logic                     go_fastica,
    input  logic                     go_fast,
    input  fastica_pkg::weight_mat_t w_in,
    input  fastica_pkg::sample_t     rd_data,
    output fastica_pkg::addr_t       rd_addr,
    output logic                     fast_busy,
    output logic                     upd_valid,
    output fastica_pkg::weight_mat_t w_upd
);

    // counts busy cycles up to N_SAMPLES+2
    logic [fastica_pkg::LOG2_N:0] cyc;
    logic rd_vld;
    logic u_vld;
    fastica_pkg::fix_t u0;
    fastica_pkg::fix_t u1;
    fastica_pkg::fix_t u0_cube;
    fastica_pkg::fix_t u1_cube;
    fastica_pkg::sample_t x_d;
    // indexed by row, then channel
    fastica_pkg::acc_t acc [2][2];

    function automatic fastica_pkg::fix_t cube(input fastica_pkg::fix_t u);
        fastica_pkg::fix_t sq;
        sq = fastica_pkg::sat_fix(fastica_pkg::qmul(u, u));
        return fastica_pkg::sat_fix(fastica_pkg::qmul(sq, u));
    endfunction

    // mean of x*u^3 minus 3w
    function automatic fastica_pkg::fix_t new_coef(input fastica_pkg::acc_t a,
                                                   input fastica_pkg::fix_t w);
        return fastica_pkg::sat_fix((a >>> fastica_pkg::LOG2_N) - 3 * fastica_pkg::acc_t'(w));
    endfunction

    assign rd_addr = cyc[fastica_pkg::LOG2_N-1:0];
    assign upd_valid = fast_busy && (cyc == fastica_pkg::N_SAMPLES + 2);
    assign u0_cube = cube(u0);
    assign u1_cube = cube(u1);

    assign w_upd.row0.c0 = new_coef(acc[0][0], w_in.row0.c0);
    assign w_upd.row0.c1 = new_coef(acc[0][1], w_in.row0.c1);
    assign w_upd.row1.c0 = new_coef(acc[1][0], w_in.row1.c0);
    assign w_upd.row1.c1 = new_coef(acc[1][1], w_in.row1.c1);

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            fast_busy <= 1'b0;
            cyc <= '0;
            rd_vld <= 1'b0;
            u_vld <= 1'b0;
        end else begin
            if (go_fast) begin
                fast_busy <= 1'b1;
                cyc <= '0;
            end else if (fast_busy) begin
                cyc <= cyc + 1'b1;
                if (cyc == fastica_pkg::N_SAMPLES + 2) begin
                    fast_busy <= 1'b0;
                end
            end
            // pipeline valids, address then projection then accumulate
            rd_vld <= fast_busy && (cyc < fastica_pkg::N_SAMPLES);
            u_vld <= rd_vld;
        end
    end

    always_ff @(posedge clk_fastica) begin
        if (rd_vld) begin
            u0 <= fastica_pkg::sat_fix(fastica_pkg::dot2(w_in.row0.c0, w_in.row0.c1,
                                                         rd_data.ch0, rd_data.ch1));
            u1 <= fastica_pkg::sat_fix(fastica_pkg::dot2(w_in.row1.c0, w_in.row1.c1,
                                                         rd_data.ch0, rd_data.ch1));
            x_d <= rd_data;
        end

        if (go_fast) begin
            acc <= '{default: '0};
        end else if (u_vld) begin
            acc[0][0] <= acc[0][0] + fastica_pkg::qmul(x_d.ch0, u0_cube);
            acc[0][1] <= acc[0][1] + fastica_pkg::qmul(x_d.ch1, u0_cube);
            acc[1][0] <= acc[1][0] + fastica_pkg::qmul(x_d.ch0, u1_cube);
            acc[1][1] <= acc[1][1] + fastica_pkg::qmul(x_d.ch1, u1_cube);
        end
    end

endmodule

/* hw/converge_check.sv */
module converge_check (
    input  logic                     clk_fastica,
    input  logic                     go_fastica,
    input  logic                     go_error,
    input  fastica_pkg::weight_mat_t w_new,
    input  fastica_pkg::weight_mat_t w_old,
    output logic                     error_busy,
    output logic                     both_conv
);

    logic second;
    fastica_pkg::acc_t dot0;
    fastica_pkg::acc_t dot1;

    // a row has settled once |new . old| reaches 1 - eps
    function automatic logic row_ok(input fastica_pkg::acc_t d);
        fastica_pkg::acc_t mag;
        mag = (d < 0) ? -d : d;
        return mag >= (fastica_pkg::acc_t'(fastica_pkg::FIX_ONE)
                       - fastica_pkg::acc_t'(fastica_pkg::CONV_EPS));
    endfunction

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            error_busy <= 1'b0;
            second <= 1'b0;
            both_conv <= 1'b0;
        end else if (go_error) begin
            error_busy <= 1'b1;
            second <= 1'b0;
        end else if (error_busy) begin
            second <= 1'b1;
            if (second) begin
                error_busy <= 1'b0;
                both_conv <= row_ok(dot0) && row_ok(dot1);
            end
        end
    end

    always_ff @(posedge clk_fastica) begin
        if (error_busy && !second) begin
            dot0 <= fastica_pkg::dot2(w_new.row0.c0, w_new.row0.c1, w_old.row0.c0, w_old.row0.c1);
            dot1 <= fastica_pkg::dot2(w_new.row1.c0, w_new.row1.c1, w_old.row1.c0, w_old.row1.c1);
        end
    end

endmodule

/* hw/fastica_controller.sv */
module fastica_controller (
    input  logic                clk_fastica,
    input  logic                go_fastica,
    input  logic                start,
    input  logic                symm_busy,
    input  logic                fast_busy,
    input  logic                error_busy,
    input  logic                both_conv,
    output logic                busy,
    output logic                done,
    output logic                go_symm,
    output logic                go_snap,
    output logic                go_fast,
    output logic                go_error,
    output logic                w_init,
    output fastica_pkg::addr_t  proj_addr,
    output logic                proj_en,
    output fastica_pkg::iter_t  iter_count,
    output logic                converged
);

    fastica_pkg::phase_t phase;
    // runs to N_SAMPLES+1 in project
    logic [fastica_pkg::LOG2_N:0] proj_cnt;

    assign busy = (phase != fastica_pkg::idle);
    assign proj_addr = proj_cnt[fastica_pkg::LOG2_N-1:0];

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            phase <= fastica_pkg::idle;
            go_symm <= 1'b0;
            go_snap <= 1'b0;
            go_fast <= 1'b0;
            go_error <= 1'b0;
            w_init <= 1'b0;
            done <= 1'b0;
            proj_en <= 1'b0;
            proj_cnt <= '0;
            iter_count <= '0;
            converged <= 1'b0;
        end else begin
            // every go is a single-cycle pulse
            go_symm <= 1'b0;
            go_snap <= 1'b0;
            go_fast <= 1'b0;
            go_error <= 1'b0;
            w_init <= 1'b0;
            done <= 1'b0;
            // lines up with data_b, one cycle behind the address
            proj_en <= (phase == fastica_pkg::project) && (proj_cnt < fastica_pkg::N_SAMPLES);

            case (phase)
                fastica_pkg::idle: begin
                    if (start) begin
                        phase <= fastica_pkg::orthogonalize;
                        go_symm <= 1'b1;
                        w_init <= 1'b1;
                        iter_count <= '0;
                        converged <= 1'b0;
                    end
                end
                fastica_pkg::orthogonalize: begin
                    // busy is only meaningful once the go cycle is over
                    if (!go_symm && !symm_busy) begin
                        phase <= fastica_pkg::snapshot;
                        go_snap <= 1'b1;
                    end
                end
                fastica_pkg::snapshot: begin
                    phase <= fastica_pkg::update;
                    go_fast <= 1'b1;
                end
                fastica_pkg::update: begin
                    if (!go_fast && !fast_busy) begin
                        phase <= fastica_pkg::converge_test;
                        go_error <= 1'b1;
                    end
                end
                fastica_pkg::converge_test: begin
                    if (!go_error && !error_busy) begin
                        iter_count <= iter_count + 1'b1;
                        if (both_conv || iter_count == fastica_pkg::iter_t'(fastica_pkg::MAX_ITER - 1)) begin
                            phase <= fastica_pkg::project;
                            converged <= both_conv;
                            proj_cnt <= '0;
                        end else begin
                            phase <= fastica_pkg::orthogonalize;
                            go_symm <= 1'b1;
                        end
                    end
                end
                fastica_pkg::project: begin
                    proj_cnt <= proj_cnt + 1'b1;
                    // last output leaves weight_bank this cycle
                    if (proj_cnt == fastica_pkg::N_SAMPLES + 1) begin
                        phase <= fastica_pkg::idle;
                        done <= 1'b1;
                    end
                end
                default: begin
                    phase <= fastica_pkg::idle;
                end
            endcase
        end
    end

endmodule

/* hw/fastica_top.sv */
module fastica_top (
    input  logic                     clk_fastica,
    input  logic                     go_fastica,
    input  logic                     start,
    input  logic                     sample_wr,
    input  fastica_pkg::addr_t       sample_addr,
    input  fastica_pkg::sample_t     sample_data,
    output logic                     busy,
    output logic                     done,
    output logic                     out_valid,
    output fastica_pkg::sample_t     out_sample,
    output fastica_pkg::weight_mat_t w_final,
    output fastica_pkg::iter_t       iter_count,
    output logic                     converged
);

    logic symm_busy;
    logic fast_busy;
    logic error_busy;
    logic both_conv;
    logic go_symm;
    logic go_snap;
    logic go_fast;
    logic go_error;
    logic w_init;
    logic proj_en;
    logic orth_valid;
    logic upd_valid;
    fastica_pkg::addr_t proj_addr;
    fastica_pkg::addr_t rd_addr;
    fastica_pkg::sample_t data_a;
    fastica_pkg::sample_t data_b;
    fastica_pkg::weight_mat_t w;
    fastica_pkg::weight_mat_t w_prev;
    fastica_pkg::weight_mat_t w_orth;
    fastica_pkg::weight_mat_t w_upd;

    // the snapshot is the last orthonormal W
    assign w_final = w_prev;

    fastica_controller u_ctrl (
        .clk_fastica(clk_fastica), .go_fastica(go_fastica), .start(start),
        .symm_busy(symm_busy), .fast_busy(fast_busy), .error_busy(error_busy),
        .both_conv(both_conv), .busy(busy), .done(done),
        .go_symm(go_symm), .go_snap(go_snap), .go_fast(go_fast), .go_error(go_error),
        .w_init(w_init), .proj_addr(proj_addr), .proj_en(proj_en),
        .iter_count(iter_count), .converged(converged)
    );

    sample_ram u_ram (
        .clk_fastica(clk_fastica), .wr(sample_wr), .busy(busy),
        .wr_addr(sample_addr), .wr_data(sample_data),
        .addr_a(rd_addr), .addr_b(proj_addr), .data_a(data_a), .data_b(data_b)
    );

    weight_bank u_wbank (
        .clk_fastica(clk_fastica), .go_fastica(go_fastica), .w_init(w_init),
        .go_snap(go_snap), .orth_valid(orth_valid), .w_orth(w_orth),
        .upd_valid(upd_valid), .w_upd(w_upd), .proj_en(proj_en), .data_b(data_b),
        .w(w), .w_prev(w_prev), .out_valid(out_valid), .out_sample(out_sample)
    );

    symm_orth u_orth (
        .clk_fastica(clk_fastica), .go_fastica(go_fastica), .go_symm(go_symm),
        .w_in(w), .symm_busy(symm_busy), .orth_valid(orth_valid), .w_orth(w_orth)
    );

    fast_update u_update (
        .clk_fastica(clk_fastica), .go_fastica(go_fastica), .go_fast(go_fast),
        .w_in(w), .rd_data(data_a), .rd_addr(rd_addr),
        .fast_busy(fast_busy), .upd_valid(upd_valid), .w_upd(w_upd)
    );

    converge_check u_conv (
        .clk_fastica(clk_fastica), .go_fastica(go_fastica), .go_error(go_error),
        .w_new(w), .w_old(w_prev), .error_busy(error_busy), .both_conv(both_conv)
    );

endmodule

/* bench/fastica_tb.sv */
module fastica_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N = fastica_pkg::N_SAMPLES;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_GAP = 3;
    // word positions in the golden file
    localparam int W_IDX = N;
    localparam int ITER_IDX = N + 1;
    localparam int CONV_IDX = N + 2;
    localparam int OUT_BASE = N + 3;
    localparam int GOLDEN_WORDS = 2 * N + 3;
    // worst case of MAX_ITER passes plus loads and resets for two runs
    localparam int RUN_CYCLES = fastica_pkg::MAX_ITER * (2 * N + 12);
    localparam int LOAD_CYCLES = N * (MAX_GAP + 1) + 4 * RESET_CYCLES;
    localparam int CYCLE_LIMIT = 2 * (RUN_CYCLES + LOAD_CYCLES);

    logic clk_fastica = 1'b0;
    logic go_fastica;
    logic start;
    logic sample_wr;
    fastica_pkg::addr_t sample_addr;
    fastica_pkg::sample_t sample_data;
    logic busy;
    logic done;
    logic out_valid;
    fastica_pkg::sample_t out_sample;
    fastica_pkg::weight_mat_t w_final;
    fastica_pkg::iter_t iter_count;
    logic converged;

    logic [63:0] golden [GOLDEN_WORDS];
    int cycle_count = 0;

    fastica_top DUT (
        .clk_fastica(clk_fastica),
        .go_fastica(go_fastica),
        .start(start),
        .sample_wr(sample_wr),
        .sample_addr(sample_addr),
        .sample_data(sample_data),
        .busy(busy),
        .done(done),
        .out_valid(out_valid),
        .out_sample(out_sample),
        .w_final(w_final),
        .iter_count(iter_count),
        .converged(converged)
    );

    always #50 clk_fastica = ~clk_fastica;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk_fastica) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    task automatic check_sample(input string name, input fastica_pkg::sample_t got,
                                input fastica_pkg::sample_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_weights(input string name, input fastica_pkg::weight_mat_t got,
                                 input fastica_pkg::weight_mat_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(input fastica_pkg::iter_t got_iter, input logic got_conv,
                                input fastica_pkg::iter_t exp_iter, input logic exp_conv);
        if (got_iter !== exp_iter) begin
            $display("FAIL iter_count: got %h expected %h", got_iter, exp_iter);
            abort_run();
        end
        if (got_conv !== exp_conv) begin
            $display("FAIL converged: got %h expected %h", got_conv, exp_conv);
            abort_run();
        end
    endtask

    task automatic verify_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic expect_idle();
        verify_flag("busy", busy, 1'b0);
        verify_flag("done", done, 1'b0);
        verify_flag("out_valid", out_valid, 1'b0);
    endtask

    // outputs drop at once on the async reset and stay low
    task automatic apply_reset(input int cycles);
        @(posedge clk_fastica);
        go_fastica <= 1'b0;
        repeat (cycles) begin
            @(negedge clk_fastica);
            expect_idle();
            check_status(iter_count, converged, '0, 1'b0);
        end
        @(posedge clk_fastica);
        go_fastica <= 1'b1;
    endtask

    task automatic load_samples();
        int i;
        int gap;
        for (i = 0; i < N; i++) begin
            gap = $urandom % (MAX_GAP + 1);
            repeat (gap) begin
                @(posedge clk_fastica);
                sample_wr <= 1'b0;
                @(negedge clk_fastica);
                expect_idle();
            end
            @(posedge clk_fastica);
            sample_wr <= 1'b1;
            sample_addr <= fastica_pkg::addr_t'(i);
            sample_data <= golden[i][31:0];
            @(negedge clk_fastica);
            expect_idle();
        end
        @(posedge clk_fastica);
        sample_wr <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk_fastica);
        start <= 1'b1;
        @(posedge clk_fastica);
        start <= 1'b0;
    endtask

    // one full run with its output stream and final status
    task automatic run_and_check(input logic disturb);
        int out_idx;
        logic finished;
        out_idx = 0;
        finished = 1'b0;
        pulse_start();
        while (!finished) begin
            @(negedge clk_fastica);
            if (out_valid) begin
                if (out_idx >= N) begin
                    $display("out_valid stayed high past %0d samples", N);
                    abort_run();
                end
                check_sample("out_sample", out_sample, golden[OUT_BASE + out_idx][31:0]);
                out_idx++;
            end else if (out_idx > 0 && out_idx < N) begin
                $display("output stream broke off after %0d of %0d samples", out_idx, N);
                abort_run();
            end
            finished = done;
            if (!finished) begin
                @(posedge clk_fastica);
                // a start and a load in mid-stream must both be dropped
                if (disturb && out_idx == N / 2) begin
                    start <= 1'b1;
                    sample_wr <= 1'b1;
                    sample_addr <= fastica_pkg::addr_t'(5);
                    sample_data <= ~golden[5][31:0];
                end else begin
                    start <= 1'b0;
                    sample_wr <= 1'b0;
                end
            end
        end
        if (out_idx != N) begin
            $display("done arrived after %0d output samples instead of %0d", out_idx, N);
            abort_run();
        end
        check_weights("w_final", w_final, golden[W_IDX]);
        check_status(iter_count, converged, golden[ITER_IDX][3:0], golden[CONV_IDX][0]);
        // done is one pulse and nothing relaunches
        @(negedge clk_fastica);
        verify_flag("busy", busy, 1'b0);
        verify_flag("done", done, 1'b0);
    endtask

    // reset lands in the middle of the output stream
    task automatic interrupt_run();
        pulse_start();
        @(negedge clk_fastica);
        while (!out_valid) begin
            @(negedge clk_fastica);
        end
        repeat (N / 2) @(negedge clk_fastica);
        verify_flag("busy", busy, 1'b1);
        verify_flag("out_valid", out_valid, 1'b1);
        apply_reset(RESET_CYCLES);
        @(negedge clk_fastica);
        expect_idle();
    endtask

    initial begin
        go_fastica <= 1'b0;
        start <= 1'b0;
        sample_wr <= 1'b0;
        sample_addr <= '0;
        sample_data <= '0;
        void'($urandom(71));
        $readmemh("bench/fastica_golden.txt", golden);
        if ($isunknown(golden[GOLDEN_WORDS - 1])) begin
            $display("golden data file is missing or holds too few words");
            abort_run();
        end
        apply_reset(RESET_CYCLES);
        load_samples();
        run_and_check(1'b1);
        run_and_check(1'b0);
        interrupt_run();
        run_and_check(1'b0);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* bench/fastica_golden.txt */
// one hex word per line: 16 input samples {ch1,ch0}, final W {row1.c1,row1.c0,row0.c1,row0.c0},
// then the iteration count, the converged flag and 16 expected output samples {ch1,ch0}
10002000
f0002000
0c00e000
f400e000
00003000
d0000000
28001800
d8001800
0400c800
fc00c800
34000a00
cc000a00
12003a00
ee003a00
0000f100
0e800000
4000000000004000
1
1
10002000
f0002000
0c00e000
f400e000
00003000
d0000000
28001800
d8001800
0400c800
fc00c800
34000a00
cc000a00
12003a00
ee003a00
0000f100
0e800000

/* fastica.f */
common/fastica_pkg.sv
hw/sample_ram.sv
hw/weight_bank.sv
hw/symm_orth/symm_orth.sv
hw/fast_update/fast_update.sv
hw/converge_check.sv
hw/fastica_controller.sv
hw/fastica_top.sv
bench/fastica_tb.sv

/* Bender.yml */
package:
  name: fastica

sources:
  - common/fastica_pkg.sv
  - hw/sample_ram.sv
  - hw/weight_bank.sv
  - hw/symm_orth/symm_orth.sv
  - hw/fast_update/fast_update.sv
  - hw/converge_check.sv
  - hw/fastica_controller.sv
  - hw/fastica_top.sv
  - target: test
    files:
      - bench/fastica_tb.sv
